// ==== src/soc_defines.svh ====
//******************************
// SoC fabric constants
//******************************

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus data width in bits
`define SOC_ARCHBITSZ 32

// Address map, base and size in words
`define SOC_DEVTBL_BASE   0
`define SOC_DEVTBL_MAPSZ  64
`define SOC_INTCTRL_BASE  64
`define SOC_INTCTRL_MAPSZ 4
`define SOC_RAM_BASE      128
`define SOC_RAM_MAPSZ     256

// Number of interrupt sources
`define SOC_IRQ_COUNT 2

// Cycles that sys_rst stays high after the reset cause goes away
`define SOC_RST_HOLD_CYCLES 16

// Device ids reported by the device table
`define SOC_DEVID_DEVTBL  7
`define SOC_DEVID_INTCTRL 3
`define SOC_DEVID_RAM     1

// Device table word that takes software reset requests
`define SOC_RST_REG_IDX 63

`endif

// ==== src/soc_pkg.sv ====
//******************************
// SoC fabric types
//******************************

`include "soc_defines.svh"

package soc_pkg;

	// PI1 bus operation, swap is handled as a read
	typedef enum logic [1:0] {
		pi1_none  = 2'b00,
		pi1_write = 2'b01,
		pi1_read  = 2'b10,
		pi1_swap  = 2'b11
	} pi1_op_t;

	typedef logic [`SOC_ARCHBITSZ-1:0] pi1_data_t;

	// Word address, byte offset bits dropped
	typedef logic [`SOC_ARCHBITSZ-3:0] pi1_addr_t;

	typedef logic [`SOC_ARCHBITSZ/8-1:0] pi1_sel_t;

	// Slave selected by the crossbar decode
	typedef enum logic [1:0] {
		slv_devtbl  = 2'd0,
		slv_intctrl = 2'd1,
		slv_ram     = 2'd2,
		slv_invalid = 2'd3
	} slave_idx_t;

endpackage

// ==== src/reset_seq.sv ====
//******************************
// Reset sequencer
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module reset_seq (
	 input  logic       clk48mhz_i
	,input  logic       rst_p
	,input  logic [1:0] swrst_req_i
	,input  logic       swrst_stb_i
	,output logic       sys_rst_o
);

	localparam int CNT_W = $clog2(`SOC_RST_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt_q;
	logic             pwr_off_q;
	logic             sw_cold;
	logic             sw_warm;
	logic             sw_off;

	// Request bits are rst1 in bit 1 and rst0 in bit 0
	assign sw_cold = swrst_stb_i && (swrst_req_i == 2'b11);
	assign sw_warm = swrst_stb_i && (swrst_req_i == 2'b10);
	assign sw_off  = swrst_stb_i && (swrst_req_i == 2'b01);

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			hold_cnt_q <= CNT_W'(`SOC_RST_HOLD_CYCLES);
			pwr_off_q  <= 1'b0;
		end else begin
			// No global reset here, so cold restarts the same way as warm
			if (sw_cold || sw_warm) begin
				hold_cnt_q <= CNT_W'(`SOC_RST_HOLD_CYCLES);
			end else if (hold_cnt_q != '0) begin
				hold_cnt_q <= hold_cnt_q - 1'b1;
			end
			// Power-off stays until the external reset
			if (sw_off) begin
				pwr_off_q <= 1'b1;
			end
		end
	end

	assign sys_rst_o = rst_p || (hold_cnt_q != '0) || pwr_off_q;

endmodule

// ==== src/pi1_xbar.sv ====
//******************************
// PI1 interconnect
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module pi1_xbar (
	 input  logic                clk48mhz_i
	,input  logic                sys_rst_i
	,input  soc_pkg::pi1_op_t    pi1_op_i
	,input  soc_pkg::pi1_addr_t  pi1_addr_i
	,input  soc_pkg::pi1_data_t  pi1_wdata_i
	,input  soc_pkg::pi1_sel_t   pi1_sel_i
	,output soc_pkg::pi1_data_t  pi1_rdata_o
	,output logic                pi1_rdy_o
	,output soc_pkg::pi1_op_t    slv_op_o
	,output soc_pkg::pi1_addr_t  slv_addr_o
	,output soc_pkg::pi1_data_t  slv_wdata_o
	,output soc_pkg::pi1_sel_t   slv_sel_o
	,output soc_pkg::slave_idx_t slv_idx_o
	,input  soc_pkg::pi1_data_t  devtbl_rdata_i
	,input  soc_pkg::pi1_data_t  intctrl_rdata_i
	,input  soc_pkg::pi1_data_t  ram_rdata_i
);

	soc_pkg::pi1_addr_t  off_devtbl;
	soc_pkg::pi1_addr_t  off_intctrl;
	soc_pkg::pi1_addr_t  off_ram;
	soc_pkg::slave_idx_t dec_idx;
	soc_pkg::pi1_addr_t  dec_off;
	logic                issue;

	soc_pkg::pi1_op_t    slv_op_q;
	soc_pkg::pi1_addr_t  slv_addr_q;
	soc_pkg::pi1_data_t  slv_wdata_q;
	soc_pkg::pi1_sel_t   slv_sel_q;
	soc_pkg::slave_idx_t slv_idx_q;
	logic                busy_q;
	logic                rdy_q;

	// Offsets wrap below the base, so one compare covers both range ends
	assign off_devtbl  = pi1_addr_i - soc_pkg::pi1_addr_t'(`SOC_DEVTBL_BASE);
	assign off_intctrl = pi1_addr_i - soc_pkg::pi1_addr_t'(`SOC_INTCTRL_BASE);
	assign off_ram     = pi1_addr_i - soc_pkg::pi1_addr_t'(`SOC_RAM_BASE);

	always_comb begin
		dec_idx = soc_pkg::slv_invalid;
		dec_off = pi1_addr_i;
		if (off_devtbl < soc_pkg::pi1_addr_t'(`SOC_DEVTBL_MAPSZ)) begin
			dec_idx = soc_pkg::slv_devtbl;
			dec_off = off_devtbl;
		end else if (off_intctrl < soc_pkg::pi1_addr_t'(`SOC_INTCTRL_MAPSZ)) begin
			dec_idx = soc_pkg::slv_intctrl;
			dec_off = off_intctrl;
		end else if (off_ram < soc_pkg::pi1_addr_t'(`SOC_RAM_MAPSZ)) begin
			dec_idx = soc_pkg::slv_ram;
			dec_off = off_ram;
		end
	end

	// A request held across rdy must not go out a second time
	assign issue = !sys_rst_i && !busy_q && (pi1_op_i != soc_pkg::pi1_none);

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			slv_op_q  <= soc_pkg::pi1_none;
			slv_idx_q <= soc_pkg::slv_invalid;
			busy_q    <= 1'b0;
			rdy_q     <= 1'b0;
		end else begin
			// Every slave answers at the edge after its op, invalid included
			rdy_q <= (slv_op_q != soc_pkg::pi1_none);
			if (issue) begin
				slv_op_q  <= pi1_op_i;
				slv_idx_q <= dec_idx;
				busy_q    <= 1'b1;
			end else begin
				slv_op_q <= soc_pkg::pi1_none;
				if (rdy_q) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (issue) begin
			slv_addr_q  <= dec_off;
			slv_wdata_q <= pi1_wdata_i;
			slv_sel_q   <= pi1_sel_i;
		end
	end

	// Response mux, unmapped space reads as zero
	always_comb begin
		case (slv_idx_q)
			soc_pkg::slv_devtbl:  pi1_rdata_o = devtbl_rdata_i;
			soc_pkg::slv_intctrl: pi1_rdata_o = intctrl_rdata_i;
			soc_pkg::slv_ram:     pi1_rdata_o = ram_rdata_i;
			default:              pi1_rdata_o = '0;
		endcase
	end

	assign pi1_rdy_o   = rdy_q;
	assign slv_op_o    = slv_op_q;
	assign slv_addr_o  = slv_addr_q;
	assign slv_wdata_o = slv_wdata_q;
	assign slv_sel_o   = slv_sel_q;
	assign slv_idx_o   = slv_idx_q;

endmodule

// ==== src/dev_table.sv ====
//******************************
// Device table
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module dev_table (
	 input  logic                clk48mhz_i
	,input  soc_pkg::pi1_op_t    slv_op_i
	,input  soc_pkg::pi1_addr_t  slv_addr_i
	,input  soc_pkg::pi1_data_t  slv_wdata_i
	,input  soc_pkg::slave_idx_t slv_idx_i
	,output soc_pkg::pi1_data_t  rdata_o
	,output logic [1:0]          swrst_req_o
	,output logic                swrst_stb_o
);

	localparam int WORD_W = $clog2(`SOC_DEVTBL_MAPSZ);

	logic               dev_hit;
	logic               rst_wr;
	logic [WORD_W-1:0]  word_idx;
	soc_pkg::pi1_data_t tbl_word;
	soc_pkg::pi1_data_t rdata_q;
	logic [1:0]         swrst_req_q;
	logic               swrst_stb_q;

	assign dev_hit  = (slv_idx_i == soc_pkg::slv_devtbl) && (slv_op_i != soc_pkg::pi1_none);
	assign word_idx = slv_addr_i[WORD_W-1:0];
	assign rst_wr   = dev_hit && (slv_op_i == soc_pkg::pi1_write)
		&& (word_idx == WORD_W'(`SOC_RST_REG_IDX));

	// Even word is the device id, odd word the map size with bit 31 for interrupt use
	always_comb begin
		case (word_idx)
			WORD_W'(0): tbl_word = soc_pkg::pi1_data_t'(`SOC_DEVID_DEVTBL);
			WORD_W'(1): tbl_word = soc_pkg::pi1_data_t'(`SOC_DEVTBL_MAPSZ);
			WORD_W'(2): tbl_word = soc_pkg::pi1_data_t'(`SOC_DEVID_INTCTRL);
			WORD_W'(3): tbl_word = {1'b1, 31'(`SOC_INTCTRL_MAPSZ)};
			WORD_W'(4): tbl_word = soc_pkg::pi1_data_t'(`SOC_DEVID_RAM);
			WORD_W'(5): tbl_word = soc_pkg::pi1_data_t'(`SOC_RAM_MAPSZ);
			default:    tbl_word = '0;
		endcase
	end

	always_ff @(posedge clk48mhz_i) begin
		if (dev_hit && (slv_op_i != soc_pkg::pi1_write)) begin
			rdata_q <= tbl_word;
		end
	end

	// Table itself is read-only, only the reset word takes writes
	always_ff @(posedge clk48mhz_i) begin
		swrst_stb_q <= rst_wr;
		if (rst_wr) begin
			swrst_req_q <= slv_wdata_i[1:0];
		end
	end

	assign rdata_o     = rdata_q;
	assign swrst_req_o = swrst_req_q;
	assign swrst_stb_o = swrst_stb_q;

endmodule

// ==== src/int_ctrl.sv ====
//******************************
// Interrupt controller
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module int_ctrl (
	 input  logic                      clk48mhz_i
	,input  logic                      sys_rst_i
	,input  logic [`SOC_IRQ_COUNT-1:0] irq_src_i
	,input  soc_pkg::pi1_op_t          slv_op_i
	,input  soc_pkg::slave_idx_t       slv_idx_i
	,output soc_pkg::pi1_data_t        rdata_o
	,output logic                      irq_o
);

	localparam int N     = `SOC_IRQ_COUNT;
	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

	logic [N-1:0]       src_q;
	logic [N-1:0]       src_prev_q;
	logic [N-1:0]       pend_q;
	logic [N-1:0]       rise;
	logic [N-1:0]       clr_mask;
	logic               claim_rd;
	logic               claim_hit;
	logic [IDX_W-1:0]   claim_idx;
	soc_pkg::pi1_data_t claim_word;
	soc_pkg::pi1_data_t rdata_q;

	assign rise     = src_q & ~src_prev_q;
	assign claim_rd = (slv_idx_i == soc_pkg::slv_intctrl)
		&& ((slv_op_i == soc_pkg::pi1_read) || (slv_op_i == soc_pkg::pi1_swap));

	// Lowest pending index wins, scan runs downward so it is found last
	always_comb begin
		claim_hit  = 1'b0;
		claim_idx  = '0;
		clr_mask   = '0;
		claim_word = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (pend_q[i]) begin
				claim_hit = 1'b1;
				claim_idx = IDX_W'(i);
			end
		end
		if (claim_hit) begin
			claim_word[31]        = 1'b1;
			claim_word[IDX_W-1:0] = claim_idx;
			if (claim_rd) begin
				clr_mask[claim_idx] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			src_q      <= '0;
			src_prev_q <= '0;
			pend_q     <= '0;
		end else begin
			src_q      <= irq_src_i;
			src_prev_q <= src_q;
			// A fresh edge on the claimed source keeps it pending
			pend_q     <= (pend_q & ~clr_mask) | rise;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (claim_rd) begin
			rdata_q <= claim_word;
		end
	end

	assign rdata_o = rdata_q;
	assign irq_o   = |pend_q;

endmodule

// ==== src/scratch_ram.sv ====
//******************************
// Scratch RAM
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module scratch_ram (
	 input  logic                clk48mhz_i
	,input  soc_pkg::pi1_op_t    slv_op_i
	,input  soc_pkg::slave_idx_t slv_idx_i
	,input  soc_pkg::pi1_addr_t  slv_addr_i
	,input  soc_pkg::pi1_data_t  slv_wdata_i
	,input  soc_pkg::pi1_sel_t   slv_sel_i
	,output soc_pkg::pi1_data_t  rdata_o
);

	localparam int AW    = $clog2(`SOC_RAM_MAPSZ);
	localparam int BYTES = `SOC_ARCHBITSZ / 8;

	soc_pkg::pi1_data_t mem [`SOC_RAM_MAPSZ];
	soc_pkg::pi1_data_t rdata_q;
	logic               ram_hit;
	logic [AW-1:0]      word_addr;

	assign ram_hit   = (slv_idx_i == soc_pkg::slv_ram) && (slv_op_i != soc_pkg::pi1_none);
	assign word_addr = slv_addr_i[AW-1:0];

	// Write merges the selected bytes, read and swap return the stored word
	always_ff @(posedge clk48mhz_i) begin
		if (ram_hit) begin
			if (slv_op_i == soc_pkg::pi1_write) begin
				for (int b = 0; b < BYTES; b++) begin
					if (slv_sel_i[b]) begin
						mem[word_addr][8*b +: 8] <= slv_wdata_i[8*b +: 8];
					end
				end
			end else begin
				rdata_q <= mem[word_addr];
			end
		end
	end

	assign rdata_o = rdata_q;

endmodule

// ==== src/soc_top.sv ====
//******************************
// SoC fabric top
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module soc_top (
	 input  logic                      clk48mhz_i
	,input  logic                      rst_p
	,input  soc_pkg::pi1_op_t          pi1_op_i
	,input  soc_pkg::pi1_addr_t        pi1_addr_i
	,input  soc_pkg::pi1_data_t        pi1_wdata_i
	,input  soc_pkg::pi1_sel_t         pi1_sel_i
	,output soc_pkg::pi1_data_t        pi1_rdata_o
	,output logic                      pi1_rdy_o
	,input  logic [`SOC_IRQ_COUNT-1:0] irq_src_i
	,output logic                      irq_o
	,output logic                      sys_rst_o
);

	logic                 sys_rst;
	logic [1:0]           swrst_req;
	logic                 swrst_stb;

	// Registered request toward the slaves
	soc_pkg::pi1_op_t     slv_op;
	soc_pkg::pi1_addr_t   slv_addr;
	soc_pkg::pi1_data_t   slv_wdata;
	soc_pkg::pi1_sel_t    slv_sel;
	soc_pkg::slave_idx_t  slv_idx;

	soc_pkg::pi1_data_t   devtbl_rdata;
	soc_pkg::pi1_data_t   intctrl_rdata;
	soc_pkg::pi1_data_t   ram_rdata;

	reset_seq u_reset_seq (
		 .clk48mhz_i  (clk48mhz_i)
		,.rst_p       (rst_p)
		,.swrst_req_i (swrst_req)
		,.swrst_stb_i (swrst_stb)
		,.sys_rst_o   (sys_rst)
	);

	pi1_xbar u_pi1_xbar (
		 .clk48mhz_i      (clk48mhz_i)
		,.sys_rst_i       (sys_rst)
		,.pi1_op_i        (pi1_op_i)
		,.pi1_addr_i      (pi1_addr_i)
		,.pi1_wdata_i     (pi1_wdata_i)
		,.pi1_sel_i       (pi1_sel_i)
		,.pi1_rdata_o     (pi1_rdata_o)
		,.pi1_rdy_o       (pi1_rdy_o)
		,.slv_op_o        (slv_op)
		,.slv_addr_o      (slv_addr)
		,.slv_wdata_o     (slv_wdata)
		,.slv_sel_o       (slv_sel)
		,.slv_idx_o       (slv_idx)
		,.devtbl_rdata_i  (devtbl_rdata)
		,.intctrl_rdata_i (intctrl_rdata)
		,.ram_rdata_i     (ram_rdata)
	);

	dev_table u_dev_table (
		 .clk48mhz_i  (clk48mhz_i)
		,.slv_op_i    (slv_op)
		,.slv_addr_i  (slv_addr)
		,.slv_wdata_i (slv_wdata)
		,.slv_idx_i   (slv_idx)
		,.rdata_o     (devtbl_rdata)
		,.swrst_req_o (swrst_req)
		,.swrst_stb_o (swrst_stb)
	);

	int_ctrl u_int_ctrl (
		 .clk48mhz_i (clk48mhz_i)
		,.sys_rst_i  (sys_rst)
		,.irq_src_i  (irq_src_i)
		,.slv_op_i   (slv_op)
		,.slv_idx_i  (slv_idx)
		,.rdata_o    (intctrl_rdata)
		,.irq_o      (irq_o)
	);

	scratch_ram u_scratch_ram (
		 .clk48mhz_i  (clk48mhz_i)
		,.slv_op_i    (slv_op)
		,.slv_idx_i   (slv_idx)
		,.slv_addr_i  (slv_addr)
		,.slv_wdata_i (slv_wdata)
		,.slv_sel_i   (slv_sel)
		,.rdata_o     (ram_rdata)
	);

	assign sys_rst_o = sys_rst;

endmodule

// ==== testbench/soc_asserts.sv ====
//******************************
// PI1 bus rules
//******************************

`timescale 1ns/10ps

module soc_asserts (
	 input logic             clk48mhz_i
	,input logic             sys_rst_i
	,input soc_pkg::pi1_op_t op_i
	,input logic             rdy_i
);

	// The master holds its request until rdy, so rdy always sees one
	rdy_has_req: assert property (@(posedge clk48mhz_i) disable iff (sys_rst_i)
		rdy_i |-> (op_i != soc_pkg::pi1_none))
		else $error("rdy high with no request on the bus");

	rdy_low_in_reset: assert property (@(posedge clk48mhz_i)
		sys_rst_i |-> !rdy_i)
		else $error("rdy high while the system reset is active");

	rdy_one_cycle: assert property (@(posedge clk48mhz_i) disable iff (sys_rst_i)
		rdy_i |=> !rdy_i)
		else $error("rdy high for two cycles in a row");

endmodule

bind pi1_xbar soc_asserts u_soc_asserts (
	 .clk48mhz_i (clk48mhz_i)
	,.sys_rst_i  (sys_rst_i)
	,.op_i       (pi1_op_i)
	,.rdy_i      (pi1_rdy_o)
);

// ==== testbench/tb_top.sv ====
//******************************
// SoC fabric testbench
//******************************

`timescale 1ns/10ps

`include "soc_defines.svh"

module tb_top;

	localparam int MAX_STEPS = 64;
	localparam int FIELDS    = 5;

	// Step kinds from the first column of the pattern file
	localparam int STEP_END     = 0;
	localparam int STEP_READ    = 1;
	localparam int STEP_WRITE   = 2;
	localparam int STEP_SWAP    = 3;
	localparam int STEP_IRQ     = 4;
	localparam int STEP_WAIT    = 5;
	localparam int STEP_IRQ_CHK = 6;
	localparam int STEP_SWRST   = 7;
	localparam int STEP_HOLD    = 8;
	localparam int STEP_PULSE   = 9;

	localparam int AW = $bits(soc_pkg::pi1_addr_t);
	localparam int SW = $bits(soc_pkg::pi1_sel_t);

	logic                      clk48mhz_i;
	logic                      rst_p;
	soc_pkg::pi1_op_t          pi1_op;
	soc_pkg::pi1_addr_t        pi1_addr;
	soc_pkg::pi1_data_t        pi1_wdata;
	soc_pkg::pi1_sel_t         pi1_sel;
	soc_pkg::pi1_data_t        pi1_rdata;
	logic                      pi1_rdy;
	logic [`SOC_IRQ_COUNT-1:0] irq_src;
	logic                      irq;
	logic                      sys_rst;

	logic [31:0] pat_mem [MAX_STEPS*FIELDS];
	int          n_steps;
	int          cycle_cnt    = 0;
	int          cycle_limit  = 1000;
	logic        result_shown = 1'b0;

	soc_top u_soc_top (
		 .clk48mhz_i  (clk48mhz_i)
		,.rst_p       (rst_p)
		,.pi1_op_i    (pi1_op)
		,.pi1_addr_i  (pi1_addr)
		,.pi1_wdata_i (pi1_wdata)
		,.pi1_sel_i   (pi1_sel)
		,.pi1_rdata_o (pi1_rdata)
		,.pi1_rdy_o   (pi1_rdy)
		,.irq_src_i   (irq_src)
		,.irq_o       (irq)
		,.sys_rst_o   (sys_rst)
	);

	initial clk48mhz_i = 1'b0;
	always #10 clk48mhz_i = ~clk48mhz_i;

	task automatic abort_run();
		result_shown = 1'b1;
		$display("Regression failed");
		$fatal(1, "Simulation stopped after the first error");
	endtask

	always @(posedge clk48mhz_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	task automatic check_word(input soc_pkg::pi1_data_t got, input soc_pkg::pi1_data_t exp,
			input int step, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: step %0d %s, got %h expected %h",
				$time, step, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input int step,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: step %0d %s, got %b expected %b",
				$time, step, what, got, exp);
			abort_run();
		end
	endtask

	// One PI1 transfer with the request held until rdy is seen
	task automatic bus_access(input soc_pkg::pi1_op_t op, input soc_pkg::pi1_addr_t addr,
			input soc_pkg::pi1_data_t wdata, input soc_pkg::pi1_sel_t sel,
			output soc_pkg::pi1_data_t rdata);
		@(posedge clk48mhz_i);
		pi1_op    <= op;
		pi1_addr  <= addr;
		pi1_wdata <= wdata;
		pi1_sel   <= sel;
		@(negedge clk48mhz_i);
		while (!pi1_rdy) begin
			@(negedge clk48mhz_i);
		end
		rdata = pi1_rdata;
		@(posedge clk48mhz_i);
		pi1_op <= soc_pkg::pi1_none;
	endtask

	// Counts cycles with sys_rst high from the next falling edge
	task automatic measure_reset(output int cycles);
		cycles = 0;
		@(negedge clk48mhz_i);
		while (sys_rst) begin
			cycles++;
			@(negedge clk48mhz_i);
		end
	endtask

	function automatic int count_steps();
		int n;
		n = 0;
		while ((n < MAX_STEPS) && (pat_mem[n*FIELDS] != STEP_END)) begin
			n++;
		end
		return n;
	endfunction

	task automatic run_step(input int step, input logic [31:0] kind, input logic [31:0] addr_w,
			input logic [31:0] data_w, input logic [31:0] sel_w, input logic [31:0] exp_w);
		soc_pkg::pi1_data_t rd;
		int                 cycles;
		case (kind)
			STEP_READ: begin
				bus_access(soc_pkg::pi1_read, addr_w[AW-1:0], data_w, sel_w[SW-1:0], rd);
				check_word(rd, exp_w, step, "read data");
			end
			STEP_WRITE: begin
				bus_access(soc_pkg::pi1_write, addr_w[AW-1:0], data_w, sel_w[SW-1:0], rd);
			end
			STEP_SWAP: begin
				bus_access(soc_pkg::pi1_swap, addr_w[AW-1:0], data_w, sel_w[SW-1:0], rd);
				check_word(rd, exp_w, step, "swap old word");
			end
			STEP_IRQ: begin
				@(posedge clk48mhz_i);
				irq_src <= data_w[`SOC_IRQ_COUNT-1:0];
			end
			STEP_WAIT: begin
				repeat (data_w) @(posedge clk48mhz_i);
			end
			STEP_IRQ_CHK: begin
				@(negedge clk48mhz_i);
				check_flag(irq, exp_w[0], step, "irq_o");
			end
			STEP_SWRST: begin
				measure_reset(cycles);
				check_word(soc_pkg::pi1_data_t'(cycles), exp_w, step, "reset hold cycles");
			end
			STEP_HOLD: begin
				repeat (data_w) begin
					@(negedge clk48mhz_i);
					check_flag(sys_rst, exp_w[0], step, "sys_rst_o level");
				end
			end
			STEP_PULSE: begin
				@(posedge clk48mhz_i);
				rst_p <= 1'b1;
				repeat (data_w) @(posedge clk48mhz_i);
				rst_p <= 1'b0;
				measure_reset(cycles);
				check_word(soc_pkg::pi1_data_t'(cycles), exp_w, step, "reset hold cycles");
				check_flag(pi1_rdy, 1'b0, step, "pi1_rdy_o after reset");
				check_flag(irq, 1'b0, step, "irq_o after reset");
			end
			default: begin
				$display("Unknown step kind %0d at step %0d", kind, step);
				abort_run();
			end
		endcase
	endtask

	initial begin
		int cycles;
		rst_p     <= 1'b1;
		pi1_op    <= soc_pkg::pi1_none;
		pi1_addr  <= '0;
		pi1_wdata <= '0;
		pi1_sel   <= '0;
		irq_src   <= '0;
		for (int i = 0; i < MAX_STEPS*FIELDS; i++) begin
			pat_mem[i] = '0;
		end
		$readmemh("testbench/soc_patterns.txt", pat_mem);
		n_steps     = count_steps();
		cycle_limit = n_steps * 8 + 200;
		if (n_steps == 0) begin
			$display("No steps were loaded from the pattern file");
			abort_run();
		end

		// Power-on reset and the hold time until the fabric is released
		repeat (5) @(posedge clk48mhz_i);
		rst_p <= 1'b0;
		measure_reset(cycles);
		check_word(soc_pkg::pi1_data_t'(cycles), soc_pkg::pi1_data_t'(`SOC_RST_HOLD_CYCLES),
			0, "power-on reset hold cycles");
		check_flag(pi1_rdy, 1'b0, 0, "pi1_rdy_o after reset");
		check_flag(irq, 1'b0, 0, "irq_o after reset");

		for (int s = 0; s < n_steps; s++) begin
			run_step(s + 1, pat_mem[s*FIELDS], pat_mem[s*FIELDS+1], pat_mem[s*FIELDS+2],
				pat_mem[s*FIELDS+3], pat_mem[s*FIELDS+4]);
		end

		result_shown = 1'b1;
		$display("Regression passed");
		$finish;
	end

	// Run stopped by a bound assertion or by the simulator itself
	final begin
		if (!result_shown) begin
			$display("Regression failed");
		end
	end

endmodule

// ==== testbench/soc_patterns.txt ====
// Columns: kind addr data sel expect, all hex
// Kinds: 1 read 2 write 3 swap 4 irq 5 wait 6 irq check 7 sw reset 8 hold 9 rst pulse 0 end
// RAM byte merge and swap
2 00000080 11223344 f 00000000
2 00000080 aabbccdd 5 00000000
1 00000080 00000000 f 11bb33dd
2 00000081 01020304 f 00000000
2 00000081 ffeeddcc a 00000000
1 00000081 00000000 f ff02dd04
2 0000017f cafef00d f 00000000
1 0000017f 00000000 f cafef00d
3 00000080 deadbeef f 11bb33dd
1 00000080 00000000 f 11bb33dd
// Device table
1 00000000 00000000 f 00000007
1 00000001 00000000 f 00000040
1 00000002 00000000 f 00000003
1 00000003 00000000 f 80000004
1 00000004 00000000 f 00000001
1 00000005 00000000 f 00000100
1 00000006 00000000 f 00000000
// Unmapped space
1 00000044 00000000 f 00000000
1 0000007f 00000000 f 00000000
1 00000180 00000000 f 00000000
1 3fffffff 00000000 f 00000000
// Interrupts, source 1 first, then source 0
6 00000000 00000000 0 00000000
4 00000000 00000002 0 00000000
5 00000000 00000003 0 00000000
6 00000000 00000000 0 00000001
4 00000000 00000003 0 00000000
5 00000000 00000003 0 00000000
1 00000040 00000000 f 80000000
6 00000000 00000000 0 00000001
1 00000040 00000000 f 80000001
6 00000000 00000000 0 00000000
1 00000040 00000000 f 00000000
4 00000000 00000000 0 00000000
// Warm reset, RAM keeps its contents
2 0000003f 00000002 f 00000000
7 00000000 00000000 0 00000010
1 00000080 00000000 f 11bb33dd
1 00000081 00000000 f ff02dd04
1 0000017f 00000000 f cafef00d
// Power-off until rst_p
2 0000003f 00000001 f 00000000
8 00000000 00000028 0 00000001
9 00000000 00000005 0 00000010
1 00000081 00000000 f ff02dd04
1 00000002 00000000 f 00000003
0 00000000 00000000 0 00000000

// ==== soc_fabric.f ====
+incdir+src
src/soc_pkg.sv
src/reset_seq.sv
src/pi1_xbar.sv
src/dev_table.sv
src/int_ctrl.sv
src/scratch_ram.sv
src/soc_top.sv
testbench/soc_asserts.sv
testbench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SoC fabric simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f soc_fabric.f --top-module tb_top \
	&& { ./obj_dir/Vtb_top > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& ! grep -q "Regression failed" sim.log \
	&& grep -q "Regression passed" sim.log \
	&& echo "Simulation run OK" \
	|| { echo "Simulation run FAILED, see sim.log"; exit 1; }
